//--- fc_params.svh
//////////////////////////////////////////////////////////////////////
// Fully connected layer parameters
// Class count, vector length, lane layout and datapath widths
// APB register byte offsets
//////////////////////////////////////////////////////////////////////
`ifndef FC_PARAMS_SVH
`define FC_PARAMS_SVH

// Layer geometry
`define FC_CLASSES      29
`define FC_WORDS        48
`define FC_LANES        8

// Widths
`define FC_LANE_W       8
`define FC_WORD_W       64
`define FC_ACC_W        24
`define FC_ADDR_W       16

// APB register map
`define FC_REG_CTRL     8'h00
`define FC_REG_FM_BASE  8'h04
`define FC_REG_W_BASE   8'h08
`define FC_REG_STATUS   8'h0C
`define FC_REG_RESULT   8'h10
`define FC_REG_SCORE    8'h14

`endif

//--- fc_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the fully connected layer
// Memory word, signed score, class index, register offsets
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "fc_params.svh"

package fc_pkg;

    // One memory word, eight int8 lanes
    typedef logic [`FC_WORD_W-1:0] word_t;

    // Accumulated dot product of one class
    typedef logic signed [`FC_ACC_W-1:0] score_t;

    // Index of one of the 29 classes
    typedef logic [4:0] class_t;

    // Byte offsets of the APB registers
    typedef enum logic [7:0] {
        REG_CTRL    = `FC_REG_CTRL,
        REG_FM_BASE = `FC_REG_FM_BASE,
        REG_W_BASE  = `FC_REG_W_BASE,
        REG_STATUS  = `FC_REG_STATUS,
        REG_RESULT  = `FC_REG_RESULT,
        REG_SCORE   = `FC_REG_SCORE
    } reg_ofs_e;

endpackage

`default_nettype wire

//--- fc_mac_if.sv
//////////////////////////////////////////////////////////////////////
// Word stream from the layer controller to the dot-product engine
// and the per-class scores coming back
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface fc_mac_if;

    // Beat qualifiers, aligned with the memory data
    logic           valid;
    logic           first;
    logic           last;

    // Weight and feature-map words of the current beat
    fc_pkg::word_t  w_word;
    fc_pkg::word_t  d_word;

    // One pulse per finished class
    logic           score_valid;
    fc_pkg::score_t score;

    // Controller side
    modport mac (
        output valid, first, last, w_word, d_word,
        input  score_valid, score
    );

    // Engine side
    modport engine (
        input  valid, first, last, w_word, d_word,
        output score_valid, score
    );

endinterface

`default_nettype wire

//--- fc_apb_regs.sv
//////////////////////////////////////////////////////////////////////
// APB register block of the fully connected layer
// Control with start bit, feature-map and weight base addresses,
// status (busy, sticky done), winning class and winning score
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module fc_apb_regs (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // APB slave
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [7:0]            i_paddr,
    input  wire logic [31:0]           i_pwdata,
    output logic      [31:0]           o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    // Layer controller
    output logic                       o_start,
    output logic      [`FC_ADDR_W-1:0] o_fm_base,
    output logic      [`FC_ADDR_W-1:0] o_w_base,
    input  wire logic                  i_busy,
    input  wire logic                  i_done,
    input  wire fc_pkg::class_t        i_class,
    input  wire fc_pkg::score_t        i_score
);

    localparam int ACC_W = `FC_ACC_W;

    fc_pkg::reg_ofs_e reg_sel;
    logic             wr_en;
    logic             done_flag;
    fc_pkg::class_t   res_class;
    fc_pkg::score_t   res_score;

    // No wait states, no error responses
    assign o_pready  = 1'b1;
    assign o_pslverr = 1'b0;

    assign reg_sel = fc_pkg::reg_ofs_e'(i_paddr);
    assign wr_en   = i_psel & i_penable & i_pwrite;

    // Start only from idle; a start during a run is dropped
    assign o_start = wr_en && (reg_sel == fc_pkg::REG_CTRL) && i_pwdata[0] && !i_busy;

    //////////////////////////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_fm_base <= '0;
            o_w_base  <= '0;
        end else if (wr_en) begin
            if (reg_sel == fc_pkg::REG_FM_BASE) begin
                o_fm_base <= i_pwdata[`FC_ADDR_W-1:0];
            end
            if (reg_sel == fc_pkg::REG_W_BASE) begin
                o_w_base <= i_pwdata[`FC_ADDR_W-1:0];
            end
        end
    end

    // Sticky done, cleared by the next accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_flag <= 1'b0;
            res_class <= '0;
            res_score <= '0;
        end else begin
            if (o_start) begin
                done_flag <= 1'b0;
            end else if (i_done) begin
                done_flag <= 1'b1;
                res_class <= i_class;
                res_score <= i_score;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read data, valid in the access cycle
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        o_prdata = '0;
        if (i_psel && !i_pwrite) begin
            case (reg_sel)
                fc_pkg::REG_FM_BASE: o_prdata = {{(32-`FC_ADDR_W){1'b0}}, o_fm_base};
                fc_pkg::REG_W_BASE:  o_prdata = {{(32-`FC_ADDR_W){1'b0}}, o_w_base};
                fc_pkg::REG_STATUS:  o_prdata = {30'b0, done_flag, i_busy};
                fc_pkg::REG_RESULT:  o_prdata = {27'b0, res_class};
                // Sign-extend the score to the bus width
                fc_pkg::REG_SCORE:   o_prdata = {{(32-ACC_W){res_score[ACC_W-1]}}, res_score};
                default:             o_prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fc_dot_engine.sv
//////////////////////////////////////////////////////////////////////
// Dot-product engine
// Stage 1: eight signed int8 by int8 products, registered
// Stage 2: adder tree and per-class accumulator, score on last beat
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module fc_dot_engine (
    input  wire logic clk,
    input  wire logic rst_n,
    fc_mac_if.engine  eng
);

    localparam int LANES  = `FC_LANES;
    localparam int LANE_W = `FC_LANE_W;
    localparam int PROD_W = 2 * LANE_W;

    logic signed [PROD_W-1:0] prod [LANES];
    logic                     s1_valid;
    logic                     s1_first;
    logic                     s1_last;

    logic signed [PROD_W:0]   sum_l1 [LANES/2];
    logic signed [PROD_W+1:0] sum_l2 [LANES/4];
    logic signed [PROD_W+2:0] sum_l3;
    fc_pkg::score_t           tree_sum;
    fc_pkg::score_t           acc;
    fc_pkg::score_t           acc_next;

    //////////////////////////////////////////////////////////////////////
    // Stage 1: lane products
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (eng.valid) begin
            for (int i = 0; i < LANES; i++) begin
                prod[i] <= $signed(eng.w_word[i*LANE_W +: LANE_W]) *
                           $signed(eng.d_word[i*LANE_W +: LANE_W]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= eng.valid;
            s1_first <= eng.valid & eng.first;
            s1_last  <= eng.valid & eng.last;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2: adder tree and accumulate
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < LANES/2; i++) begin
            sum_l1[i] = (PROD_W+1)'(prod[2*i]) + (PROD_W+1)'(prod[2*i+1]);
        end
        for (int i = 0; i < LANES/4; i++) begin
            sum_l2[i] = (PROD_W+2)'(sum_l1[2*i]) + (PROD_W+2)'(sum_l1[2*i+1]);
        end
        sum_l3 = (PROD_W+3)'(sum_l2[0]) + (PROD_W+3)'(sum_l2[1]);
    end

    assign tree_sum = fc_pkg::score_t'(sum_l3);

    // A first beat restarts the sum, so classes follow without a gap
    assign acc_next = s1_first ? tree_sum : acc + tree_sum;

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            acc <= acc_next;
        end
        if (s1_valid && s1_last) begin
            eng.score <= acc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eng.score_valid <= 1'b0;
        end else begin
            eng.score_valid <= s1_valid & s1_last;
        end
    end

endmodule

`default_nettype wire

//--- fc_layer_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Layer controller
// Address generation for feature-map and weight memories,
// stream qualifiers, running argmax and end of run
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module fc_layer_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  i_start,
    input  wire logic [`FC_ADDR_W-1:0] i_fm_base,
    input  wire logic [`FC_ADDR_W-1:0] i_w_base,
    output logic      [`FC_ADDR_W-1:0] o_fm_addr,
    output logic      [`FC_ADDR_W-1:0] o_w_addr,
    input  wire fc_pkg::word_t         i_fm_data,
    input  wire fc_pkg::word_t         i_w_data,
    output logic                       o_busy,
    output logic                       o_done,
    output fc_pkg::class_t             o_class,
    output fc_pkg::score_t             o_score,
    fc_mac_if                          mac
);

    localparam int             ADDR_W     = `FC_ADDR_W;
    localparam logic [5:0]     WORD_LAST  = 6'(`FC_WORDS - 1);
    localparam fc_pkg::class_t CLASS_LAST = 5'(`FC_CLASSES - 1);

    logic              issuing;
    logic [5:0]        word_cnt;
    fc_pkg::class_t    class_cnt;
    logic [ADDR_W-1:0] row_ofs;
    fc_pkg::class_t    score_cnt;

    //////////////////////////////////////////////////////////////////////
    // Address sequencing, one pair per cycle
    //////////////////////////////////////////////////////////////////////
    assign o_fm_addr = i_fm_base + ADDR_W'(word_cnt);
    assign o_w_addr  = i_w_base + row_ofs + ADDR_W'(word_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_busy    <= 1'b0;
            issuing   <= 1'b0;
            word_cnt  <= '0;
            class_cnt <= '0;
            row_ofs   <= '0;
        end else begin
            if (i_start) begin
                o_busy    <= 1'b1;
                issuing   <= 1'b1;
                word_cnt  <= '0;
                class_cnt <= '0;
                row_ofs   <= '0;
            end else if (issuing) begin
                if (word_cnt == WORD_LAST) begin
                    word_cnt  <= '0;
                    class_cnt <= class_cnt + 1'b1;
                    // Next weight row, c * 48 kept as a running offset
                    row_ofs   <= row_ofs + ADDR_W'(`FC_WORDS);
                    if (class_cnt == CLASS_LAST) begin
                        issuing <= 1'b0;
                    end
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
            // Busy drops the cycle after the done pulse
            if (o_done) begin
                o_busy <= 1'b0;
            end
        end
    end

    // Flags follow the addresses by one cycle, like the read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac.valid <= 1'b0;
            mac.first <= 1'b0;
            mac.last  <= 1'b0;
        end else begin
            mac.valid <= issuing;
            mac.first <= issuing && (word_cnt == '0);
            mac.last  <= issuing && (word_cnt == WORD_LAST);
        end
    end

    assign mac.w_word = i_w_data;
    assign mac.d_word = i_fm_data;

    //////////////////////////////////////////////////////////////////////
    // Argmax over returned scores
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score_cnt <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= mac.score_valid && (score_cnt == CLASS_LAST);
            if (i_start) begin
                score_cnt <= '0;
            end else if (mac.score_valid) begin
                score_cnt <= score_cnt + 1'b1;
            end
        end
    end

    // Strictly greater replaces, so ties keep the lower class
    always_ff @(posedge clk) begin
        if (mac.score_valid && ((score_cnt == '0) || (mac.score > o_score))) begin
            o_score <= mac.score;
            o_class <= score_cnt;
        end
    end

    fc_dot_engine u_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .eng   (mac)
    );

endmodule

`default_nettype wire

//--- fc_top.sv
//////////////////////////////////////////////////////////////////////
// Fully connected classifier stage, top level
// APB register block, layer controller with dot-product engine,
// feature-map and weight memory ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module fc_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // APB
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [7:0]            i_paddr,
    input  wire logic [31:0]           i_pwdata,
    output logic      [31:0]           o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    // External memories, one-cycle synchronous read
    output logic      [`FC_ADDR_W-1:0] o_fm_addr,
    output logic      [`FC_ADDR_W-1:0] o_w_addr,
    input  wire fc_pkg::word_t         i_fm_data,
    input  wire fc_pkg::word_t         i_w_data,
    output logic                       o_done
);

    logic                  start;
    logic [`FC_ADDR_W-1:0] fm_base;
    logic [`FC_ADDR_W-1:0] w_base;
    logic                  busy;
    fc_pkg::class_t        win_class;
    fc_pkg::score_t        win_score;

    fc_mac_if u_mac_if ();

    fc_apb_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_start   (start),
        .o_fm_base (fm_base),
        .o_w_base  (w_base),
        .i_busy    (busy),
        .i_done    (o_done),
        .i_class   (win_class),
        .i_score   (win_score)
    );

    fc_layer_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_start   (start),
        .i_fm_base (fm_base),
        .i_w_base  (w_base),
        .o_fm_addr (o_fm_addr),
        .o_w_addr  (o_w_addr),
        .i_fm_data (i_fm_data),
        .i_w_data  (i_w_data),
        .o_busy    (busy),
        .o_done    (o_done),
        .o_class   (win_class),
        .o_score   (win_score),
        .mac       (u_mac_if)
    );

endmodule

`default_nettype wire

//--- fc_asserts.sv
//////////////////////////////////////////////////////////////////////
// Protocol assertions for the layer controller
// Engine latency, stream qualifiers, done pulse and busy window
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module fc_asserts (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic i_valid,
    input wire logic i_first,
    input wire logic i_last,
    input wire logic i_score_valid,
    input wire logic i_busy,
    input wire logic i_done
);

    // Two engine stages between the last beat and its score
    assert property (@(posedge clk) disable iff (!rst_n)
        (i_valid && i_last) |-> ##2 i_score_valid)
        else $error("score_valid not 2 cycles after last beat");

    // A class is 48 back-to-back beats from first to last
    assert property (@(posedge clk) disable iff (!rst_n)
        (i_valid && i_first) |-> ##(`FC_WORDS - 1) (i_valid && i_last))
        else $error("last beat not 48 beats after the first beat of a class");

    // Single-cycle done, busy released right after
    assert property (@(posedge clk) disable iff (!rst_n)
        i_done |=> (!i_done && !i_busy))
        else $error("done not a single pulse or busy still high");

    assert property (@(posedge clk) disable iff (!rst_n)
        i_valid |-> i_busy)
        else $error("valid beat while the layer is idle");

endmodule

bind fc_layer_ctrl fc_asserts u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (mac.valid),
    .i_first       (mac.first),
    .i_last        (mac.last),
    .i_score_valid (mac.score_valid),
    .i_busy        (o_busy),
    .i_done        (o_done)
);

`default_nettype wire

//--- tb_fc_top.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the fully connected layer
// Memory models, APB tasks, reference argmax, compare process,
// timeout and closing report
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module tb_fc_top;

    localparam int TIMEOUT    = 6 * (`FC_CLASSES * `FC_WORDS + 100);
    localparam int RUN_CYCLES = `FC_CLASSES * `FC_WORDS + 4;

    logic clk, rst_n;
    logic psel, penable, pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata, prdata;
    logic pready, pslverr, done;
    logic [15:0] fm_addr, w_addr;
    fc_pkg::word_t fm_data, w_data;
    fc_pkg::word_t fm_mem [0:65535];
    fc_pkg::word_t w_mem [0:65535];
    logic [31:0] exp_result, exp_score, got_result, got_score;
    int errors, checks, cycles, start_cycle;
    event result_ready;

    fc_top u_dut (
        .clk (clk), .rst_n (rst_n),
        .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
        .i_paddr (paddr), .i_pwdata (pwdata), .o_prdata (prdata),
        .o_pready (pready), .o_pslverr (pslverr),
        .o_fm_addr (fm_addr), .o_w_addr (w_addr),
        .i_fm_data (fm_data), .i_w_data (w_data), .o_done (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Both memories answer one clock after the address
    always @(posedge clk) begin
        fm_data <= fm_mem[fm_addr];
        w_data  <= w_mem[w_addr];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the layer did not finish within %0d cycles", TIMEOUT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // Expected winner: 29 dot products, strictly greater replaces
    function automatic void ref_argmax(input logic [15:0] fm_base, input logic [15:0] w_base,
                                       output logic [31:0] best_class,
                                       output logic [31:0] best_score);
        int score, best;
        fc_pkg::word_t fw, ww;
        best = 0;
        best_class = '0;
        for (int c = 0; c < `FC_CLASSES; c++) begin
            score = 0;
            for (int k = 0; k < `FC_WORDS; k++) begin
                fw = fm_mem[16'(fm_base + 16'(k))];
                ww = w_mem[16'(w_base + 16'(c * `FC_WORDS + k))];
                for (int l = 0; l < `FC_LANES; l++) begin
                    score += int'($signed(fw[l*8 +: 8])) * int'($signed(ww[l*8 +: 8]));
                end
            end
            if (c == 0 || score > best) begin
                best = score;
                best_class = 32'(c);
            end
        end
        best_score = 32'(best);
    endfunction

    task automatic apb_write(input fc_pkg::reg_ofs_e ofs, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= ofs;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input fc_pkg::reg_ofs_e ofs, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= ofs;
        @(posedge clk);
        penable <= 1'b1;
        // Read data settles in the access cycle
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic set_bases(input logic [15:0] fm_base, input logic [15:0] w_base);
        apb_write(fc_pkg::REG_FM_BASE, 32'(fm_base));
        apb_write(fc_pkg::REG_W_BASE, 32'(w_base));
        ref_argmax(fm_base, w_base, exp_result, exp_score);
    endtask

    // Start a run and note its access cycle for the done latency
    task automatic start_layer();
        apb_write(fc_pkg::REG_CTRL, 32'h1);
        // Counter still holds the access cycle in this time step
        start_cycle = cycles;
    endtask

    // Polls the sticky done bit, then hands the result to the compare process
    task automatic collect_result();
        logic [31:0] status;
        status = '0;
        while (!status[1]) begin
            apb_read(fc_pkg::REG_STATUS, status);
        end
        apb_read(fc_pkg::REG_RESULT, got_result);
        apb_read(fc_pkg::REG_SCORE, got_score);
        -> result_ready;
        @(posedge clk);
    endtask

    initial begin
        forever begin
            @(result_ready);
            check_value("RESULT", got_result, exp_result);
            check_value("SCORE", got_score, exp_score);
        end
    end

    // APB response and done timing, sampled mid-cycle
    always @(negedge clk) begin
        if (psel && penable) begin
            check_value("o_pready", 32'(pready), 32'h1);
            check_value("o_pslverr", 32'(pslverr), 32'h0);
        end
        if (done) begin
            check_value("o_done latency", 32'(cycles - start_cycle), 32'(RUN_CYCLES));
        end
    end

    initial begin
        logic [31:0] rd;
        void'($urandom(40));
        errors = 0;
        checks = 0;
        cycles = 0;
        start_cycle = 0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        fm_data <= '0;
        w_data <= '0;
        rst_n <= 1'b0;
        for (int a = 0; a < 65536; a++) begin
            fm_mem[a] = {$urandom, $urandom};
            w_mem[a]  = {$urandom, $urandom};
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        //////////////////////////////////////////////////////////////////////
        // Random run, then the same run with a start while busy
        //////////////////////////////////////////////////////////////////////
        set_bases(16'h0120, 16'h1000);
        start_layer();
        collect_result();
        start_layer();
        repeat (200) @(posedge clk);
        apb_write(fc_pkg::REG_CTRL, 32'h1);
        apb_read(fc_pkg::REG_STATUS, rd);
        check_value("STATUS", rd, 32'h1);
        collect_result();

        // Rows 7 and 20 identical and maximal over nonnegative features
        for (int k = 0; k < `FC_WORDS; k++) begin
            fm_mem[16'h0200 + k] = {$urandom, $urandom} & 64'h7f7f_7f7f_7f7f_7f7f;
            w_mem[16'h2000 + 7 * `FC_WORDS + k]  = 64'h7f7f_7f7f_7f7f_7f7f;
            w_mem[16'h2000 + 20 * `FC_WORDS + k] = 64'h7f7f_7f7f_7f7f_7f7f;
        end
        set_bases(16'h0200, 16'h2000);
        exp_result = 32'd7;
        start_layer();
        collect_result();

        // Positive features against negative weights, every score below zero
        for (int k = 0; k < `FC_WORDS; k++) begin
            fm_mem[16'h0300 + k] = ({$urandom, $urandom} & 64'h7f7f_7f7f_7f7f_7f7f)
                                   | 64'h0101_0101_0101_0101;
        end
        for (int a = 0; a < `FC_CLASSES * `FC_WORDS; a++) begin
            w_mem[16'h4000 + a] = w_mem[16'h4000 + a] | 64'h8080_8080_8080_8080;
        end
        set_bases(16'h0300, 16'h4000);
        start_layer();
        collect_result();

        // Back-to-back run on new bases with register readback
        set_bases(16'h3456, 16'h8000);
        apb_read(fc_pkg::REG_FM_BASE, rd);
        check_value("FM_BASE", rd, 32'h3456);
        apb_read(fc_pkg::REG_W_BASE, rd);
        check_value("W_BASE", rd, 32'h8000);
        start_layer();
        apb_read(fc_pkg::REG_STATUS, rd);
        check_value("STATUS", rd, 32'h1);
        collect_result();

        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
fc_pkg.sv
fc_mac_if.sv
fc_apb_regs.sv
fc_dot_engine.sv
fc_layer_ctrl.sv
fc_top.sv
fc_asserts.sv
tb_fc_top.sv

//--- run.sh
#!/bin/sh
# Build the fully connected layer testbench with Verilator and run it.
# The run passes only if the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_fc_top \
    -o tb_fc_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_fc_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
